// File: Bender.yml
package:
  name: cpu_ctrl

export_include_dirs:
  - .

sources:
  - cpu_ctrl_pkg.sv
  - jump_cond.sv
  - first_decode.sv
  - second_decode.sv
  - ctrl_seq.sv
  - cpu_ctrl.sv
  - target: simulation
    files:
      - cpu_ctrl_properties.sv
      - tb_cpu_ctrl.sv

// File: cpu_ctrl.sv
// Top of the instruction controller
// Joins both decoders and the condition evaluator to the sequencer
`include "cpu_ctrl_defs.svh"

module cpu_ctrl import cpu_ctrl_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                cen,
    input  logic [`OP_W-1:0]    op,
    input  logic                op_ok,
    input  logic [7:0]          flags,
    output logic [2:0]          fetched,
    output logic                pc_rel,
    output logic                flag_we,
    output alu_op_t             alu_op,
    output logic [31:0]         alu_imm,
    output logic                alu_smux,
    output logic                alu_wait,
    output logic [2:0]          regs_we,
    output logic [`RCODE_W-1:0] regs_dst,
    output logic [`RCODE_W-1:0] regs_src
);

    logic jump_ok;
    phase_t f_phase, s_phase;
    logic [2:0] f_nbytes, s_nbytes, f_we_mask, s_we_mask;
    logic [`RCODE_W-1:0] f_dst, f_src, s_dst, s_src, pre_reg;
    alu_op_t f_alu_op, s_alu_op;
    logic [31:0] f_imm, s_imm;
    logic f_smux, f_fill, f_flag_we, f_pc_rel;
    logic s_smux, s_fill, s_flag_we;
    logic [1:0] f_size, size;

    jump_cond u_jump_cond (
        .flags   (flags),
        .cond    (cond_t'(op[3:0])),
        .jump_ok (jump_ok)
    );

    first_decode u_first_decode (
        .op         (op),
        .jump_ok    (jump_ok),
        .nx_phase   (f_phase),
        .nbytes     (f_nbytes),
        .dst        (f_dst),
        .src        (f_src),
        .alu_op_nx  (f_alu_op),
        .imm        (f_imm),
        .smux       (f_smux),
        .fill       (f_fill),
        .flag_we_nx (f_flag_we),
        .pc_rel_nx  (f_pc_rel),
        .we_mask    (f_we_mask),
        .size       (f_size)
    );

    second_decode u_second_decode (
        .op         (op),
        .pre_reg    (pre_reg),
        .size       (size),
        .nx_phase   (s_phase),
        .nbytes     (s_nbytes),
        .dst        (s_dst),
        .src        (s_src),
        .alu_op_nx  (s_alu_op),
        .imm        (s_imm),
        .smux       (s_smux),
        .fill       (s_fill),
        .flag_we_nx (s_flag_we),
        .we_mask    (s_we_mask)
    );

    ctrl_seq u_ctrl_seq (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen),
        .op_ok     (op_ok),
        .op        (op),
        .f_phase   (f_phase),
        .f_nbytes  (f_nbytes),
        .f_dst     (f_dst),
        .f_src     (f_src),
        .f_alu_op  (f_alu_op),
        .f_imm     (f_imm),
        .f_smux    (f_smux),
        .f_fill    (f_fill),
        .f_flag_we (f_flag_we),
        .f_pc_rel  (f_pc_rel),
        .f_we_mask (f_we_mask),
        .f_size    (f_size),
        .s_phase   (s_phase),
        .s_nbytes  (s_nbytes),
        .s_dst     (s_dst),
        .s_src     (s_src),
        .s_alu_op  (s_alu_op),
        .s_imm     (s_imm),
        .s_smux    (s_smux),
        .s_fill    (s_fill),
        .s_flag_we (s_flag_we),
        .s_we_mask (s_we_mask),
        .fetched   (fetched),
        .pc_rel    (pc_rel),
        .flag_we   (flag_we),
        .alu_smux  (alu_smux),
        .alu_wait  (alu_wait),
        .alu_op    (alu_op),
        .alu_imm   (alu_imm),
        .regs_we   (regs_we),
        .regs_dst  (regs_dst),
        .regs_src  (regs_src),
        .pre_reg   (pre_reg),
        .size      (size)
    );

endmodule

// File: cpu_ctrl_defs.svh
// Shared widths, flag bit positions and size codes for the instruction controller
// Include in any file that needs them; the guard makes repeated includes harmless
`ifndef CPU_CTRL_DEFS_SVH
`define CPU_CTRL_DEFS_SVH

`define OP_W     32     // Opcode window, four bytes little endian
`define RCODE_W  8      // Expanded register code

`define FLAG_S   7      // Sign
`define FLAG_Z   6      // Zero
`define FLAG_V   2      // Overflow / parity
`define FLAG_C   0      // Carry

`define SZ_BYTE  2'd0   // zz size field
`define SZ_WORD  2'd1
`define SZ_LONG  2'd2

`endif

// File: cpu_ctrl_pkg.sv
// Types and helper functions shared by the controller blocks and its testbench
// Import with cpu_ctrl_pkg::* in the module header
`include "cpu_ctrl_defs.svh"

package cpu_ctrl_pkg;

    typedef enum logic [1:0] {
        PH_FETCH,
        PH_EXEC,   // Second byte of a register prefixed instruction
        PH_FILL    // Upper immediate bytes
    } phase_t;

    typedef enum logic [5:0] {
        ALU_NOP, ALU_MOVE,
        ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBC,
        ALU_AND, ALU_XOR, ALU_OR, ALU_CP,
        ALU_INC, ALU_DEC, ALU_CPL, ALU_NEG,
        ALU_RCF, ALU_SCF, ALU_CCF, ALU_ZCF
    } alu_op_t;

    // Code order follows the cc nibble of JR
    typedef enum logic [3:0] {
        F, LT, LE, ULE, OV, MI, EQ, C,
        T, GE, GT, UGT, NOV, PL, NE, NC
    } cond_t;

    // Short register number to full register code
    function automatic logic [`RCODE_W-1:0] reg_code(input logic [2:0] r, input logic [1:0] sz);
        if (sz == `SZ_BYTE)
            return {4'he, r[2:1], 1'b0, ~r[0]};   // W,A,B,C,D,E,H,L pairing
        else if (r[2])
            return {4'hf, r[1:0], 2'd0};          // XIX..XSP
        else
            return {4'he, r[1:0], 2'd0};          // XWA..XHL
    endfunction

    function automatic logic [2:0] size_mask(input logic [1:0] sz);
        case (sz)
            `SZ_BYTE: return 3'b001;
            `SZ_WORD: return 3'b010;
            default:  return 3'b100;
        endcase
    endfunction

endpackage

// File: cpu_ctrl_properties.sv
// Concurrent checks on the sequencer strobes, window refill and fill phase
// Bound into ctrl_seq so the internal ram_wait is visible
module cpu_ctrl_properties (
    input logic       clk,
    input logic       rst,
    input logic       cen,
    input logic       ram_wait,
    input logic [2:0] fetched,
    input logic [2:0] regs_we,
    input logic       flag_we,
    input logic       pc_rel,
    input logic       alu_wait
);

    timeunit 1ns;
    timeprecision 1ps;

    assert property (@(posedge clk) disable iff (rst) $onehot0(regs_we))
        else $error("regs_we has more than one bit set");

    // Window is being refilled after every fetch
    assert property (@(posedge clk) disable iff (rst)
                     fetched != 3'd0 |=> ram_wait && fetched == 3'd0)
        else $error("no wait cycle with fetched zero after a fetch");

    // A stalled cycle cannot produce a strobe on the next edge
    assert property (@(posedge clk) disable iff (rst)
                     !cen |=> (regs_we == 3'd0 && !flag_we && !pc_rel))
        else $error("strobe after a cycle with cen low");

    // Pending write is held back until the fill advance
    assert property (@(posedge clk) disable iff (rst)
                     alu_wait |-> (regs_we == 3'd0 && !flag_we && !pc_rel))
        else $error("strobe while alu_wait is high");

endmodule

bind ctrl_seq cpu_ctrl_properties u_properties (
    .clk      (clk),
    .rst      (rst),
    .cen      (cen),
    .ram_wait (ram_wait),
    .fetched  (fetched),
    .regs_we  (regs_we),
    .flag_we  (flag_we),
    .pc_rel   (pc_rel),
    .alu_wait (alu_wait)
);

// File: ctrl_seq.sv
// Instruction sequencer, owns the phase and registers every control output
// Takes the first decoder in PH_FETCH, the second in PH_EXEC and runs PH_FILL itself
`include "cpu_ctrl_defs.svh"

module ctrl_seq import cpu_ctrl_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                cen,
    input  logic                op_ok,
    input  logic [`OP_W-1:0]    op,
    input  phase_t              f_phase,
    input  logic [2:0]          f_nbytes,
    input  logic [`RCODE_W-1:0] f_dst,
    input  logic [`RCODE_W-1:0] f_src,
    input  alu_op_t             f_alu_op,
    input  logic [31:0]         f_imm,
    input  logic                f_smux,
    input  logic                f_fill,
    input  logic                f_flag_we,
    input  logic                f_pc_rel,
    input  logic [2:0]          f_we_mask,
    input  logic [1:0]          f_size,
    input  phase_t              s_phase,
    input  logic [2:0]          s_nbytes,
    input  logic [`RCODE_W-1:0] s_dst,
    input  logic [`RCODE_W-1:0] s_src,
    input  alu_op_t             s_alu_op,
    input  logic [31:0]         s_imm,
    input  logic                s_smux,
    input  logic                s_fill,
    input  logic                s_flag_we,
    input  logic [2:0]          s_we_mask,
    output logic [2:0]          fetched,
    output logic                pc_rel,
    output logic                flag_we,
    output logic                alu_smux,
    output logic                alu_wait,
    output alu_op_t             alu_op,
    output logic [31:0]         alu_imm,
    output logic [2:0]          regs_we,
    output logic [`RCODE_W-1:0] regs_dst,
    output logic [`RCODE_W-1:0] regs_src,
    output logic [`RCODE_W-1:0] pre_reg,
    output logic [1:0]          size
);

    phase_t  phase, sel_phase;
    logic    ram_wait, advance;
    logic    pend_flag;
    logic [2:0] pend_we;                        // Write held back until the fill ends
    logic [2:0] sel_nbytes, sel_we_mask;
    logic [`RCODE_W-1:0] sel_dst, sel_src;
    alu_op_t sel_alu_op;
    logic [31:0] sel_imm;
    logic    sel_smux, sel_fill, sel_flag_we;

    assign advance  = cen && op_ok && !ram_wait;
    assign alu_wait = phase == PH_FILL;

    always_comb begin
        sel_phase   = phase == PH_EXEC ? s_phase   : f_phase;
        sel_nbytes  = phase == PH_EXEC ? s_nbytes  : f_nbytes;
        sel_dst     = phase == PH_EXEC ? s_dst     : f_dst;
        sel_src     = phase == PH_EXEC ? s_src     : f_src;
        sel_alu_op  = phase == PH_EXEC ? s_alu_op  : f_alu_op;
        sel_imm     = phase == PH_EXEC ? s_imm     : f_imm;
        sel_smux    = phase == PH_EXEC ? s_smux    : f_smux;
        sel_fill    = phase == PH_EXEC ? s_fill    : f_fill;
        sel_flag_we = phase == PH_EXEC ? s_flag_we : f_flag_we;
        sel_we_mask = phase == PH_EXEC ? s_we_mask : f_we_mask;
    end

    always_comb begin
        fetched = 3'd0;
        if (advance)
            fetched = phase == PH_FILL ? (size == `SZ_LONG ? 3'd3 : 3'd1) : sel_nbytes;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase     <= PH_FETCH;
            ram_wait  <= 1'b0;
            regs_we   <= 3'd0;
            flag_we   <= 1'b0;
            pc_rel    <= 1'b0;
            alu_op    <= ALU_NOP;
            alu_imm   <= 32'd0;
            alu_smux  <= 1'b0;
            regs_dst  <= '0;
            regs_src  <= '0;
            pre_reg   <= '0;
            size      <= `SZ_BYTE;
            pend_we   <= 3'd0;
            pend_flag <= 1'b0;
        end else begin
            regs_we <= 3'd0;                    // Strobes last one cycle
            flag_we <= 1'b0;
            pc_rel  <= 1'b0;
            if (cen)
                ram_wait <= fetched != 3'd0;    // Memory refills the window
            if (advance) begin
                if (phase == PH_FILL) begin
                    if (size == `SZ_LONG)
                        alu_imm[31:8] <= op[23:0];
                    else
                        alu_imm[15:8] <= op[7:0];
                    regs_we   <= pend_we;
                    flag_we   <= pend_flag;
                    pend_we   <= 3'd0;
                    pend_flag <= 1'b0;
                    phase     <= PH_FETCH;
                end else begin
                    phase    <= sel_phase;
                    alu_op   <= sel_alu_op;
                    alu_imm  <= sel_imm;
                    alu_smux <= sel_smux;
                    regs_dst <= sel_dst;
                    regs_src <= sel_src;
                    pc_rel   <= phase == PH_FETCH && f_pc_rel;
                    if (phase == PH_FETCH) begin
                        pre_reg <= f_dst;       // Prefix register for the EXEC byte
                        size    <= f_size;
                    end
                    if (sel_fill) begin
                        pend_we   <= sel_we_mask;
                        pend_flag <= sel_flag_we;
                    end else begin
                        regs_we <= sel_we_mask;
                        flag_we <= sel_flag_we;
                    end
                end
            end
        end
    end

endmodule

// File: first_decode.sv
// First opcode byte decoder, proposes what the sequencer does on a fetch advance
// Purely combinational; the sequencer decides whether the proposal is taken
`include "cpu_ctrl_defs.svh"

module first_decode import cpu_ctrl_pkg::*; (
    input  logic [`OP_W-1:0]    op,
    input  logic                jump_ok,
    output phase_t              nx_phase,
    output logic [2:0]          nbytes,
    output logic [`RCODE_W-1:0] dst,
    output logic [`RCODE_W-1:0] src,
    output alu_op_t             alu_op_nx,
    output logic [31:0]         imm,
    output logic                smux,
    output logic                fill,
    output logic                flag_we_nx,
    output logic                pc_rel_nx,
    output logic [2:0]          we_mask,
    output logic [1:0]          size
);

    always_comb begin
        nx_phase   = PH_FETCH;
        nbytes     = 3'd1;     // Unknown bytes are skipped as NOP
        dst        = '0;
        src        = '0;
        alu_op_nx  = ALU_NOP;
        imm        = 32'd0;
        smux       = 1'b0;
        fill       = 1'b0;
        flag_we_nx = 1'b0;
        pc_rel_nx  = 1'b0;
        we_mask    = 3'd0;
        size       = `SZ_BYTE;
        casez (op[7:0])
            8'h00, 8'h20: ;                       // NOP
            8'b0001_00??: begin                   // RCF SCF CCF ZCF
                flag_we_nx = 1'b1;
                case (op[1:0])
                    2'd0:    alu_op_nx = ALU_RCF;
                    2'd1:    alu_op_nx = ALU_SCF;
                    2'd2:    alu_op_nx = ALU_CCF;
                    default: alu_op_nx = ALU_ZCF;
                endcase
            end
            8'b0010_0???, 8'b0011_0???, 8'b0100_0???: begin  // LD R,#
                size = op[6:4] == 3'd2 ? `SZ_BYTE :
                       op[6:4] == 3'd3 ? `SZ_WORD : `SZ_LONG;
                dst       = reg_code(op[2:0], size);
                src       = dst;
                alu_op_nx = ALU_MOVE;
                imm       = {24'd0, op[15:8]};    // Low byte, the rest comes in the fill
                smux      = 1'b1;
                nbytes    = 3'd2;
                we_mask   = size_mask(size);
                fill      = size != `SZ_BYTE;
                nx_phase  = fill ? PH_FILL : PH_FETCH;
            end
            8'b011?_????: begin                   // JR cc
                if (op[4]) begin
                    imm    = {{16{op[23]}}, op[23:8]} + 32'd3;
                    nbytes = 3'd3;
                end else begin
                    imm    = {{24{op[15]}}, op[15:8]} + 32'd2;
                    nbytes = 3'd2;
                end
                pc_rel_nx = jump_ok;
            end
            8'b110?_1???, 8'b1110_1???: begin     // Register prefix, zz=11 excluded
                size     = op[5:4];
                dst      = reg_code(op[2:0], size);
                src      = dst;
                nx_phase = PH_EXEC;
            end
            default: ;
        endcase
    end

endmodule

// File: jump_cond.sv
// Condition evaluator for JR cc
// Combinational, takes the live flag byte and the cc nibble
`include "cpu_ctrl_defs.svh"

module jump_cond import cpu_ctrl_pkg::*; (
    input  logic [7:0] flags,
    input  cond_t      cond,
    output logic       jump_ok
);

    logic fs, fz, fv, fc;

    assign fs = flags[`FLAG_S];
    assign fz = flags[`FLAG_Z];
    assign fv = flags[`FLAG_V];
    assign fc = flags[`FLAG_C];

    always_comb begin
        case (cond)
            F:       jump_ok = 1'b0;
            LT:      jump_ok = fs ^ fv;              // Signed less than
            LE:      jump_ok = fz | (fs ^ fv);
            ULE:     jump_ok = fz | fc;              // Unsigned
            OV:      jump_ok = fv;
            MI:      jump_ok = fs;
            EQ:      jump_ok = fz;
            C:       jump_ok = fc;
            T:       jump_ok = 1'b1;
            GE:      jump_ok = ~(fs ^ fv);
            GT:      jump_ok = ~(fz | (fs ^ fv));
            UGT:     jump_ok = ~(fz | fc);
            NOV:     jump_ok = ~fv;
            PL:      jump_ok = ~fs;
            NE:      jump_ok = ~fz;
            default: jump_ok = ~fc;                  // NC
        endcase
    end

endmodule

// File: second_decode.sv
// Second byte decoder for register prefixed instructions
// Uses the register and size recorded at the prefix advance
`include "cpu_ctrl_defs.svh"

module second_decode import cpu_ctrl_pkg::*; (
    input  logic [`OP_W-1:0]    op,
    input  logic [`RCODE_W-1:0] pre_reg,
    input  logic [1:0]          size,
    output phase_t              nx_phase,
    output logic [2:0]          nbytes,
    output logic [`RCODE_W-1:0] dst,
    output logic [`RCODE_W-1:0] src,
    output alu_op_t             alu_op_nx,
    output logic [31:0]         imm,
    output logic                smux,
    output logic                fill,
    output logic                flag_we_nx,
    output logic [2:0]          we_mask
);

    // Same op order in the register and immediate groups
    function automatic alu_op_t alu_code(input logic [2:0] code);
        case (code)
            3'd0:    return ALU_ADD;
            3'd1:    return ALU_ADC;
            3'd2:    return ALU_SUB;
            3'd3:    return ALU_SBC;
            3'd4:    return ALU_AND;
            3'd5:    return ALU_XOR;
            3'd6:    return ALU_OR;
            default: return ALU_CP;
        endcase
    endfunction

    always_comb begin
        nx_phase   = PH_FETCH;
        nbytes     = 3'd1;
        dst        = pre_reg;
        src        = pre_reg;
        alu_op_nx  = ALU_NOP;
        imm        = 32'd0;
        smux       = 1'b0;
        fill       = 1'b0;
        flag_we_nx = 1'b0;
        we_mask    = 3'd0;
        casez (op[7:0])
            8'b1???_0???: begin                   // ALU R,r
                dst        = reg_code(op[2:0], size);
                alu_op_nx  = alu_code(op[6:4]);
                flag_we_nx = 1'b1;
                we_mask    = op[6:4] == 3'd7 ? 3'd0 : size_mask(size);  // CP keeps R
            end
            8'b1100_1???: begin                   // ALU r,#
                alu_op_nx  = alu_code(op[2:0]);
                imm        = {24'd0, op[15:8]};
                smux       = 1'b1;
                nbytes     = 3'd2;
                flag_we_nx = 1'b1;
                we_mask    = op[2:0] == 3'd7 ? 3'd0 : size_mask(size);
                fill       = size != `SZ_BYTE;
                nx_phase   = fill ? PH_FILL : PH_FETCH;
            end
            8'b1000_1???: begin                   // LD R,r
                dst       = reg_code(op[2:0], size);
                alu_op_nx = ALU_MOVE;
                we_mask   = size_mask(size);
            end
            8'b1001_1???: begin                   // LD r,R
                src       = reg_code(op[2:0], size);
                alu_op_nx = ALU_MOVE;
                we_mask   = size_mask(size);
            end
            8'b0110_????: begin                   // INC/DEC #3, zero stands for 8
                alu_op_nx  = op[3] ? ALU_DEC : ALU_INC;
                imm        = {28'd0, op[2:0] == 3'd0, op[2:0]};
                smux       = 1'b1;
                flag_we_nx = 1'b1;
                we_mask    = size_mask(size);
            end
            8'b0000_011?: begin                   // CPL, NEG
                alu_op_nx  = op[0] ? ALU_NEG : ALU_CPL;
                flag_we_nx = 1'b1;
                we_mask    = size_mask(size);
            end
            default: ;
        endcase
    end

endmodule

// File: sim.f
+incdir+.
cpu_ctrl_pkg.sv
jump_cond.sv
first_decode.sv
second_decode.sv
ctrl_seq.sv
cpu_ctrl.sv
cpu_ctrl_properties.sv
tb_cpu_ctrl.sv

// File: tb_cpu_ctrl.sv
// Randomized testbench for the instruction controller
// Builds an LCG instruction stream, feeds it through a sliding window and checks every strobe
`include "cpu_ctrl_defs.svh"

module tb_cpu_ctrl import cpu_ctrl_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_INST  = 300;
    localparam int TIMEOUT = 20000;

    typedef struct packed {
        logic [1:0]  kind;                       // 1 write, 2 flags only, 3 jump
        logic [2:0]  mask;
        logic [7:0]  dst;
        logic [7:0]  src;
        alu_op_t     op;
        logic [31:0] imm;
        logic        smux;                       // Immediate operand selected
        logic        flg;
    } event_t;

    logic clk, rst, cen, op_ok;
    logic [`OP_W-1:0] op;
    logic [7:0]  flags;
    logic [2:0]  fetched, regs_we;
    logic        pc_rel, flag_we, alu_smux, alu_wait;
    alu_op_t     alu_op;
    logic [31:0] alu_imm;
    logic [7:0]  regs_dst, regs_src;

    logic [31:0] lcg_state;
    logic [7:0]  stream[$];
    event_t      inst_ev[N_INST];                // Kind 0 means no strobe
    logic        inst_jr[N_INST];
    logic        inst_fill[N_INST];              // Last advance is a fill
    logic [3:0]  inst_cc[N_INST];
    int          inst_steps[N_INST][3];          // Bytes per advance
    int          inst_nsteps[N_INST];
    event_t      exp_q[$];
    int          pos, cur_inst, cur_step, errors, checks, cycles;

    cpu_ctrl u_cpu_ctrl (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .op       (op),
        .op_ok    (op_ok),
        .flags    (flags),
        .fetched  (fetched),
        .pc_rel   (pc_rel),
        .flag_we  (flag_we),
        .alu_op   (alu_op),
        .alu_imm  (alu_imm),
        .alu_smux (alu_smux),
        .alu_wait (alu_wait),
        .regs_we  (regs_we),
        .regs_dst (regs_dst),
        .regs_src (regs_src)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return {8'd0, lcg_state[31:8]};          // Low bits of an LCG are weak
    endfunction

    // TLCS-900 cc table with the upper half as complement of the lower half
    function automatic logic cond_holds(input logic [3:0] cc, input logic [7:0] fl);
        logic fs, fz, fv, fc, base;
        fs = fl[`FLAG_S];
        fz = fl[`FLAG_Z];
        fv = fl[`FLAG_V];
        fc = fl[`FLAG_C];
        case (cc[2:0])
            3'd0:    base = 1'b0;
            3'd1:    base = fs ^ fv;
            3'd2:    base = fz | (fs ^ fv);
            3'd3:    base = fz | fc;
            3'd4:    base = fv;
            3'd5:    base = fs;
            3'd6:    base = fz;
            default: base = fc;
        endcase
        return base ^ cc[3];
    endfunction

    function automatic logic [7:0] window_byte(input int idx);
        if (idx < stream.size())
            return stream[idx];
        return 8'h00;
    endfunction

    task automatic log_mismatch(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        $display("ERROR %0t %s got %0h expected %0h", $time, name, got, exp);
        errors++;
    endtask

    task automatic set_steps(input int i, input int a, input int b, input int c);
        inst_steps[i][0] = a;
        inst_steps[i][1] = b;
        inst_steps[i][2] = c;
        inst_nsteps[i]   = (a != 0) + (b != 0) + (c != 0);
    endtask

    // Low byte goes with the opcode and the rest arrives in the fill advance
    task automatic push_imm(input logic [1:0] sz, inout logic [31:0] imm, output int fill);
        stream.push_back(imm[7:0]);
        fill = 0;
        if (sz == `SZ_BYTE) begin
            imm = {24'd0, imm[7:0]};
        end else if (sz == `SZ_WORD) begin
            stream.push_back(imm[15:8]);
            imm  = {16'd0, imm[15:0]};
            fill = 1;
        end else begin
            stream.push_back(imm[15:8]);
            stream.push_back(imm[23:16]);
            stream.push_back(imm[31:24]);
            fill = 3;
        end
    endtask

    task automatic build_instruction(input int i);
        logic [31:0] r, imm, lo, hi;
        logic [2:0]  reg_a, reg_b, code;
        logic [1:0]  sz;
        logic [7:0]  pre, other;
        int          fill;
        event_t      ev;
        r     = lcg_next();
        lo    = lcg_next();
        hi    = lcg_next();
        imm   = {hi[15:0], lo[15:0]};
        reg_a = r[10:8];
        reg_b = r[13:11];
        code  = r[16:14];
        sz    = r[18:17] == 2'd3 ? `SZ_LONG : r[18:17];
        pre   = reg_code(reg_a, sz);
        other = reg_code(reg_b, sz);
        ev    = '0;
        fill  = 0;
        inst_jr[i] = 1'b0;
        inst_cc[i] = r[23:20];
        set_steps(i, 1, 0, 0);
        case (r[7:0] % 8)
            0: stream.push_back(8'h00);          // NOP
            1: begin                             // RCF SCF CCF ZCF
                stream.push_back({6'b000100, code[1:0]});
                ev.kind = 2'd2;
                ev.flg  = 1'b1;
                ev.op   = alu_op_t'(ALU_RCF + code[1:0]);
            end
            2, 3: begin                          // LD R,#
                if (sz == `SZ_BYTE && reg_a == 3'd0)
                    reg_a = 3'd1;
                stream.push_back({1'b0, 3'd2 + {1'b0, sz}, 1'b0, reg_a});
                push_imm(sz, imm, fill);
                set_steps(i, 2, fill, 0);
                ev.kind = 2'd1;
                ev.mask = size_mask(sz);
                ev.dst  = reg_code(reg_a, sz);
                ev.src  = ev.dst;
                ev.op   = ALU_MOVE;
                ev.imm  = imm;
                ev.smux = 1'b1;
            end
            4: begin                             // JR cc
                stream.push_back({3'b011, r[19], r[23:20]});
                stream.push_back(imm[7:0]);
                ev.kind    = 2'd3;
                inst_jr[i] = 1'b1;
                if (r[19]) begin
                    stream.push_back(imm[15:8]);
                    ev.imm = {{16{imm[15]}}, imm[15:0]} + 32'd3;
                    set_steps(i, 3, 0, 0);
                end else begin
                    ev.imm = {{24{imm[7]}}, imm[7:0]} + 32'd2;
                    set_steps(i, 2, 0, 0);
                end
            end
            default: begin                       // Register prefix then second byte
                stream.push_back({2'b11, sz, 1'b1, reg_a});
                set_steps(i, 1, 1, 0);
                ev.kind = 2'd1;
                ev.mask = size_mask(sz);
                ev.dst  = pre;
                ev.src  = pre;
                ev.flg  = 1'b1;
                case (r[26:24])
                    0, 1: begin                  // ALU R,r
                        stream.push_back({1'b1, code, 1'b0, reg_b});
                        ev.dst = other;
                        ev.op  = alu_op_t'(ALU_ADD + code);
                    end
                    2, 3: begin                  // ALU r,#
                        stream.push_back({5'b11001, code});
                        push_imm(sz, imm, fill);
                        set_steps(i, 1, 2, fill);
                        ev.op   = alu_op_t'(ALU_ADD + code);
                        ev.imm  = imm;
                        ev.smux = 1'b1;
                    end
                    4: begin                     // INC/DEC where zero means 8
                        stream.push_back({4'b0110, r[27], reg_b});
                        ev.op   = r[27] ? ALU_DEC : ALU_INC;
                        ev.imm  = reg_b == 3'd0 ? 32'd8 : {29'd0, reg_b};
                        ev.smux = 1'b1;
                    end
                    5: begin
                        stream.push_back({7'b0000011, r[27]});
                        ev.op = r[27] ? ALU_NEG : ALU_CPL;
                    end
                    6: begin                     // LD R,r
                        stream.push_back({5'b10001, reg_b});
                        ev.dst = other;
                        ev.op  = ALU_MOVE;
                        ev.flg = 1'b0;
                    end
                    default: begin               // LD r,R
                        stream.push_back({5'b10011, reg_b});
                        ev.src = other;
                        ev.op  = ALU_MOVE;
                        ev.flg = 1'b0;
                    end
                endcase
                if (ev.op == ALU_CP) begin       // Compare only sets flags
                    ev.kind = 2'd2;
                    ev.mask = 3'd0;
                end
            end
        endcase
        inst_fill[i] = fill != 0;
        inst_ev[i]   = ev;
    endtask

    task automatic drive_inputs();
        logic [31:0] r;
        r     = lcg_next();
        cen   = r[2:0] != 3'd0;
        op_ok = r[5:3] != 3'd0 && pos < stream.size();
        flags = r[13:6];
        op    = {window_byte(pos + 3), window_byte(pos + 2), window_byte(pos + 1),
                 window_byte(pos)};
    endtask

    task automatic track_advance();
        if ((!cen || !op_ok) && fetched != 3'd0)
            log_mismatch("fetched", fetched, 0);
        if (fetched != 3'd0) begin
            checks++;
            if (cur_inst >= N_INST) begin
                $display("bytes consumed past the end of the stream at %0t", $time);
                errors++;
            end else begin
                if (fetched != inst_steps[cur_inst][cur_step])
                    log_mismatch("fetched", fetched, inst_steps[cur_inst][cur_step]);
                // Jumps are queued only if taken with the flags of this cycle
                if (cur_step == 0 && inst_ev[cur_inst].kind != 2'd0 &&
                    (!inst_jr[cur_inst] || cond_holds(inst_cc[cur_inst], flags)))
                    exp_q.push_back(inst_ev[cur_inst]);
                cur_step++;
                if (cur_step == inst_nsteps[cur_inst]) begin
                    cur_inst++;
                    cur_step = 0;
                end
            end
            pos += fetched;
        end
    endtask

    // The fill advance is always the last one of an instruction
    task automatic check_fill_wait();
        logic exp_wait;
        exp_wait = cur_inst < N_INST && cur_step != 0 && inst_fill[cur_inst] &&
                   cur_step == inst_nsteps[cur_inst] - 1;
        if (alu_wait != exp_wait)
            log_mismatch("alu_wait", alu_wait, exp_wait);
    endtask

    task automatic check_pulses();
        event_t e;
        if (regs_we != 3'd0 || flag_we || pc_rel) begin
            checks++;
            if (exp_q.size() == 0) begin
                $display("unexpected strobe at %0t with no instruction waiting for one", $time);
                errors++;
            end else begin
                e = exp_q.pop_front();
                if (regs_we != e.mask)
                    log_mismatch("regs_we", regs_we, e.mask);
                if (flag_we != e.flg)
                    log_mismatch("flag_we", flag_we, e.flg);
                if (pc_rel != (e.kind == 2'd3))
                    log_mismatch("pc_rel", pc_rel, e.kind == 2'd3);
                if (e.kind != 2'd3 && alu_op != e.op)
                    log_mismatch("alu_op", alu_op, e.op);
                if (e.kind != 2'd3 && alu_smux != e.smux)
                    log_mismatch("alu_smux", alu_smux, e.smux);
                if (e.kind == 2'd1 && regs_dst != e.dst)
                    log_mismatch("regs_dst", regs_dst, e.dst);
                if (e.kind == 2'd1 && regs_src != e.src)
                    log_mismatch("regs_src", regs_src, e.src);
                if (e.kind != 2'd2 && alu_imm != e.imm)
                    log_mismatch("alu_imm", alu_imm, e.imm);
            end
        end
    endtask

    initial begin
        rst       = 1'b1;
        cen       = 1'b0;
        op_ok     = 1'b0;
        op        = '0;
        flags     = 8'd0;
        lcg_state = 32'h42a8;
        errors    = 0;
        checks    = 0;
        pos       = 0;
        cur_inst  = 0;
        cur_step  = 0;
        for (int i = 0; i < N_INST; i++)
            build_instruction(i);
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        if (alu_op != ALU_NOP)
            log_mismatch("alu_op", alu_op, ALU_NOP);
        if (regs_we != 3'd0 || flag_we || pc_rel || alu_wait)
            log_mismatch("strobes", {regs_we, flag_we, pc_rel, alu_wait}, 0);
        if (alu_imm != 32'd0)
            log_mismatch("alu_imm", alu_imm, 0);
        cycles = 0;
        while ((cur_inst < N_INST || exp_q.size() != 0) && cycles < TIMEOUT) begin
            @(negedge clk);
            check_pulses();
            check_fill_wait();
            drive_inputs();
            #1;
            track_advance();
            cycles++;
        end
        if (cycles >= TIMEOUT) begin
            $display("timeout after %0d cycles with %0d instructions done", cycles, cur_inst);
            errors++;
        end
        op_ok = 1'b0;
        repeat (4) begin                         // No stray strobes once idle
            @(negedge clk);
            check_pulses();
        end
        if (pos != stream.size())
            log_mismatch("bytes consumed", pos, stream.size());
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule
